// File: Makefile
# Verilator build and run of the pipelined Kogge-Stone adder testbench.
# Any variable can be overridden on the command line, e.g. make sim JOBS=8

VERILATOR ?= verilator
TOP       ?= ks_adder_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# build, then run; a $fatal in the run gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --timescale $(TIMESCALE) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/ks_adder_checker.sv
//--------------------------------------------------------------------------
// Concurrent assertions on the adder top level, bound into ks_adder_top.
// Covers valid latency, reset behaviour and known result bits.
//--------------------------------------------------------------------------

`default_nettype none

module ks_adder_checker
	import ks_adder_cfg_pkg::*;
	import ks_adder_types_pkg::*;
(
	input wire logic  clk,
	input wire logic  rst_n,
	input wire logic  in_valid,
	input wire logic  out_valid,
	input wire word_t sum,
	input wire logic  carry_out
);

	timeunit 1ns;
	timeprecision 1ps;

	// every accepted pair comes out after the pipeline depth
	a_valid_latency : assert property (@(posedge clk) disable iff (!rst_n)
		$past(in_valid, ks_latency) |-> out_valid)
		else $error("in_valid was not followed by out_valid after %0d cycles", ks_latency);

	// no result without a matching operand pair
	a_no_spurious_valid : assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(in_valid, ks_latency))
		else $error("out_valid without in_valid %0d cycles earlier", ks_latency);

	// valid registers clear under reset
	a_reset_clears_valid : assert property (@(posedge clk)
		!rst_n |=> !out_valid)
		else $error("out_valid high while reset was held");

	// result fully driven whenever it is presented
	a_result_known : assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown({sum, carry_out}))
		else $error("sum or carry_out has unknown bits while out_valid is high");

endmodule : ks_adder_checker

`default_nettype wire

// File: dv/ks_adder_tb.sv
//--------------------------------------------------------------------------
// Testbench for the pipelined Kogge-Stone adder. Drives corner, random and
// single-bit operands, checks every result against a 33-bit model sum and
// its arrival cycle, and stops at the first mismatch or on timeout.
//--------------------------------------------------------------------------

`default_nettype none

module ks_adder_tb
	import ks_adder_cfg_pkg::*;
	import ks_adder_types_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_corner    = 6;
	localparam int n_random    = 1000;
	localparam int total_ops   = n_corner + 2 * n_random + ks_adder_width;
	localparam int cycle_limit = 2 * total_ops + 50;

	logic  clk;
	logic  rst_n;
	logic  in_valid;
	word_t a;
	word_t b;
	logic  out_valid;
	word_t sum;
	logic  carry_out;

	int cycle = 0;

	// model results in issue order
	// each with its issue cycle and test name
	logic [ks_adder_width:0] exp_q [$];
	int                      stamp_q [$];
	string                   name_q [$];

	ks_adder_top i_ks_adder_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.sum       (sum),
		.carry_out (carry_out)
	);

	bind ks_adder_top ks_adder_checker i_ks_adder_checker (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.out_valid (out_valid),
		.sum       (sum),
		.carry_out (carry_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit)
		begin
			$display("timeout: run went past %0d cycles", cycle_limit);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	task automatic compare_value(input string name, input logic [63:0] exp_val,
		input logic [63:0] act_val);
		if (exp_val !== act_val)
		begin
			$display("ERR %s: expected 0x%0h, actual 0x%0h", name, exp_val, act_val);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// one operand pair per cycle
	// model result queued only when valid
	task automatic drive_op(input string name, input logic v, input word_t op_a,
		input word_t op_b);
		@(negedge clk);
		in_valid = v;
		a        = op_a;
		b        = op_b;
		if (v)
		begin
			exp_q.push_back({1'b0, op_a} + {1'b0, op_b});
			stamp_q.push_back(cycle);
			name_q.push_back(name);
		end
	endtask

	task automatic wait_drained();
		@(negedge clk);
		in_valid = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	//----------------------------------------------------------------------
	// result monitor
	//----------------------------------------------------------------------

	always @(negedge clk)
	begin
		logic [ks_adder_width:0] exp_res;
		int                      stamp;
		string                   name;
		if (out_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("out_valid went high with no addition in flight");
				$display("tests failed");
				$fatal(1, "unexpected result");
			end
			else
			begin
				exp_res = exp_q.pop_front();
				stamp   = stamp_q.pop_front();
				name    = name_q.pop_front();
				compare_value({name, " sum"}, 64'(exp_res[ks_adder_width-1:0]), 64'(sum));
				compare_value({name, " carry_out"}, 64'(exp_res[ks_adder_width]),
					64'(carry_out));
				compare_value({name, " latency"}, 64'(stamp + ks_latency), 64'(cycle));
			end
		end
	end

	//----------------------------------------------------------------------
	// stimulus
	//----------------------------------------------------------------------

	initial
	begin
		int issued;
		logic v;
		void'($urandom(24340));
		rst_n    = 1'b0;
		in_valid = 1'b0;
		a        = '0;
		b        = '0;

		repeat (2)
		begin
			@(negedge clk);
			compare_value("reset", 64'(0), 64'(out_valid));
		end
		rst_n = 1'b1;
		repeat (4)
		begin
			@(negedge clk);
			compare_value("after reset", 64'(0), 64'(out_valid));
		end

		// alternating pairs ripple a carry through every bit
		drive_op("zero", 1'b1, 32'h0000_0000, 32'h0000_0000);
		drive_op("ones plus one", 1'b1, 32'hffff_ffff, 32'h0000_0001);
		drive_op("max positive plus one", 1'b1, 32'h7fff_ffff, 32'h0000_0001);
		drive_op("ripple 5", 1'b1, 32'h5555_5555, 32'haaaa_aaab);
		drive_op("ripple a", 1'b1, 32'haaaa_aaaa, 32'h5555_5556);
		drive_op("ones plus ones", 1'b1, 32'hffff_ffff, 32'hffff_ffff);
		wait_drained();

		repeat (n_random)
			drive_op("back to back", 1'b1, $urandom(), $urandom());
		wait_drained();

		issued = 0;
		while (issued < n_random)
		begin
			v = ($urandom_range(0, 1) != 0);
			drive_op("gaps", v, $urandom(), $urandom());
			if (v)
				issued++;
		end
		wait_drained();

		for (int k = 0; k < ks_adder_width; k++)
			drive_op("single bit", 1'b1, word_t'(1) << k, '1);
		@(negedge clk);
		in_valid = 1'b0;
		// idle past the pipeline depth for the last result and any stray out_valid
		repeat (ks_latency + 2)
			@(negedge clk);

		if (exp_q.size() != 0)
		begin
			$display("results still pending at the end of the run");
			$display("tests failed");
			$fatal(1, "pending results");
		end
		else
		begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule : ks_adder_tb

`default_nettype wire

// File: source/ks_adder_cfg_pkg.sv
//--------------------------------------------------------------------------
// Size constants for the pipelined Kogge-Stone adder.
// The stages and the testbench import these by wildcard.
//--------------------------------------------------------------------------

`default_nettype none

package ks_adder_cfg_pkg;

	// operand and sum width in bits
	localparam int ks_adder_width = 32;

	// prefix tree depth, log2 of the width
	localparam int ks_levels = 5;

	// cycles from in_valid to out_valid
	// one register each after pg, prefix tree and sum
	localparam int ks_latency = 3;

endpackage : ks_adder_cfg_pkg

`default_nettype wire

// File: source/ks_adder_top.sv
//--------------------------------------------------------------------------
// Top level of the three-stage pipelined Kogge-Stone adder. Plain ports;
// in_valid with a and b gives out_valid with sum and carry_out three
// clocks later, one new pair accepted every cycle.
//--------------------------------------------------------------------------

`default_nettype none

module ks_adder_top
	import ks_adder_types_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  in_valid,
	input  word_t a,
	input  word_t b,
	output logic  out_valid,
	output word_t sum,
	output logic  carry_out
);

	// prefix tree to sum stage
	logic  carry_valid;
	word_t carry;
	word_t carry_x;

	// pg stage to prefix tree
	ks_pg_if i_pg_if ();

	ks_pg_gen i_ks_pg_gen (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.a        (a),
		.b        (b),
		.pg       (i_pg_if.producer)
	);

	ks_prefix_tree i_ks_prefix_tree (
		.clk         (clk),
		.rst_n       (rst_n),
		.pg          (i_pg_if.consumer),
		.carry_valid (carry_valid),
		.carry       (carry),
		.carry_x     (carry_x)
	);

	ks_sum_stage i_ks_sum_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.carry_valid (carry_valid),
		.carry       (carry),
		.carry_x     (carry_x),
		.out_valid   (out_valid),
		.sum         (sum),
		.carry_out   (carry_out)
	);

endmodule : ks_adder_top

`default_nettype wire

// File: source/ks_adder_types_pkg.sv
//--------------------------------------------------------------------------
// Data types and the prefix combine operator shared by the adder stages.
//--------------------------------------------------------------------------

`default_nettype none

package ks_adder_types_pkg;

	import ks_adder_cfg_pkg::*;

	typedef logic [ks_adder_width-1:0] word_t;

	// one node of the prefix tree
	typedef struct packed
	{
		logic g;
		logic p;
	} gp_t;

	// merge a higher group with the group just below it
	function automatic gp_t gp_combine(input gp_t hi, input gp_t lo);
		gp_t res;
		res.g = hi.g | (hi.p & lo.g);
		res.p = hi.p & lo.p;
		return res;
	endfunction

endpackage : ks_adder_types_pkg

`default_nettype wire

// File: source/ks_pg_gen.sv
//--------------------------------------------------------------------------
// First pipeline stage of the adder. Forms per-bit generate, propagate and
// half-sum from the operands and registers them onto the pg interface.
//--------------------------------------------------------------------------

`default_nettype none

module ks_pg_gen
	import ks_adder_types_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_valid,
	input  word_t     a,
	input  word_t     b,
	ks_pg_if.producer pg
);

	word_t g_next;
	word_t p_next;
	word_t x_next;

	// carry is created at a bit when both operand bits are set
	assign g_next = a & b;
	// OR form of propagate, enough for the carry tree
	assign p_next = a | b;
	// the sum needs a true xor, so carry it separately
	assign x_next = a ^ b;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pg.valid <= 1'b0;
		else
			pg.valid <= in_valid;
	end

	// payload loads only with a valid operand pair
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			pg.g <= g_next;
			pg.p <= p_next;
			pg.x <= x_next;
		end
	end

endmodule : ks_pg_gen

`default_nettype wire

// File: source/ks_pg_if.sv
//--------------------------------------------------------------------------
// Carries the registered generate, propagate and half-sum words from the
// pg stage into the prefix tree, with a one-cycle valid strobe.
//--------------------------------------------------------------------------

`default_nettype none

interface ks_pg_if
	import ks_adder_types_pkg::*;
();

	// data is only meaningful while valid is high
	logic  valid;
	word_t g;
	word_t p;
	// half-sum, a xor b
	word_t x;

	modport producer (
		output valid, g, p, x
	);

	modport consumer (
		input valid, g, p, x
	);

endinterface : ks_pg_if

`default_nettype wire

// File: source/ks_prefix_tree.sv
//--------------------------------------------------------------------------
// Kogge-Stone parallel-prefix carry network. Takes the registered pg words,
// runs them through ks_levels rows of combine nodes and registers the
// carries together with the delayed half-sum.
//--------------------------------------------------------------------------

`default_nettype none

module ks_prefix_tree
	import ks_adder_cfg_pkg::*;
	import ks_adder_types_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	ks_pg_if.consumer pg,
	output logic      carry_valid,
	output word_t     carry,
	output word_t     carry_x
);

	// row 0 holds the leaves, row ks_levels the finished groups
	gp_t   row [0:ks_levels][ks_adder_width-1:0];
	word_t carry_next;

	genvar lvl;
	genvar i;

	//----------------------------------------------------------------------
	// leaves
	//----------------------------------------------------------------------

	generate
		for (i = 0; i < ks_adder_width; i++)
		begin : g_leaf
			assign row[0][i] = '{g: pg.g[i], p: pg.p[i]};
		end
	endgenerate

	//----------------------------------------------------------------------
	// prefix rows
	//----------------------------------------------------------------------

	// span doubles each row: 1, 2, 4, 8, 16
	generate
		for (lvl = 0; lvl < ks_levels; lvl++)
		begin : g_level
			for (i = 0; i < ks_adder_width; i++)
			begin : g_node
				if (i >= (1 << lvl))
				begin : g_merge
					assign row[lvl+1][i] = gp_combine(row[lvl][i],
						row[lvl][i-(1 << lvl)]);
				end
				else
				begin : g_pass
					// partner would sit below bit 0, group is already complete
					assign row[lvl+1][i] = row[lvl][i];
				end
			end
		end
	endgenerate

	// group generate from bit i down to bit 0 is the carry out of bit i
	generate
		for (i = 0; i < ks_adder_width; i++)
		begin : g_carry
			assign carry_next[i] = row[ks_levels][i].g;
		end
	endgenerate

	//----------------------------------------------------------------------
	// output register
	//----------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			carry_valid <= 1'b0;
		else
			carry_valid <= pg.valid;
	end

	always_ff @(posedge clk)
	begin
		if (pg.valid)
		begin
			carry   <= carry_next;
			// half-sum rides along to line up with its carries
			carry_x <= pg.x;
		end
	end

endmodule : ks_prefix_tree

`default_nettype wire

// File: source/ks_sum_stage.sv
//--------------------------------------------------------------------------
// Last pipeline stage of the adder. Combines the half-sum with the carry of
// the bit below and registers sum, carry out and valid.
//--------------------------------------------------------------------------

`default_nettype none

module ks_sum_stage
	import ks_adder_cfg_pkg::*;
	import ks_adder_types_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  carry_valid,
	input  word_t carry,
	input  word_t carry_x,
	output logic  out_valid,
	output word_t sum,
	output logic  carry_out
);

	word_t carry_in;
	word_t sum_next;

	// carry into bit i is carry out of bit i-1, zero into bit 0
	assign carry_in = {carry[ks_adder_width-2:0], 1'b0};
	assign sum_next = carry_x ^ carry_in;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= carry_valid;
	end

	always_ff @(posedge clk)
	begin
		if (carry_valid)
		begin
			sum       <= sum_next;
			// top carry is already in the tree output
			carry_out <= carry[ks_adder_width-1];
		end
	end

endmodule : ks_sum_stage

`default_nettype wire

// File: vlog.f
source/ks_adder_cfg_pkg.sv
source/ks_adder_types_pkg.sv
source/ks_pg_if.sv
source/ks_pg_gen.sv
source/ks_prefix_tree.sv
source/ks_sum_stage.sv
source/ks_adder_top.sv
dv/ks_adder_checker.sv
dv/ks_adder_tb.sv
